/* Makefile */
# Verilator build and run of the processor testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh)
STIM    := verification/cpu_stim.txt

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(STIM)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
+incdir+src
src/cpu_pkg.sv
src/fetch_fsm.sv
src/pc_counter.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/cpu.sv
verification/cpu_tb.sv

/* src/cpu.sv */
// processor top level
// fetch fsm, pc counter, decode, register file and execute

module cpu import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	output imem_req_t imem_req,
	input  imem_rsp_t imem_rsp,
	output wb_t       wb,
	output word_t     pc,
	output logic      hlt
);

	// fetch to decode
	logic     fetch_valid;
	instr_t   fetch_instr;
	logic     pc_step;

	// decode to register file
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	word_t    rs_data;
	word_t    rt_data;

	// execute results back up the pipe
	id_ex_t   id_ex;
	branch_t  branch;
	logic     halt_retired;

	////////////////////////////////////////////////////////////
	// front end
	////////////////////////////////////////////////////////////

	fetch_fsm fetch0 (
		.clk          (clk),
		.rst          (rst),
		.imem_rsp     (imem_rsp),
		.imem_req     (imem_req),
		.pc           (pc),
		.branch       (branch),
		.halt_retired (halt_retired),
		.fetch_valid  (fetch_valid),
		.fetch_instr  (fetch_instr),
		.pc_step      (pc_step),
		.hlt          (hlt)
	);

	pc_counter pc0 (
		.clk     (clk),
		.rst     (rst),
		.pc_step (pc_step),
		.branch  (branch),
		.pc      (pc)
	);

	////////////////////////////////////////////////////////////
	// decode, registers, execute
	////////////////////////////////////////////////////////////

	decode_stage decode0 (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch_instr (fetch_instr),
		.rs_idx      (rs_idx),
		.rt_idx      (rt_idx),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.wb          (wb),
		.id_ex       (id_ex)
	);

	register_file regs0 (
		.clk     (clk),
		.rst     (rst),
		.rs_idx  (rs_idx),
		.rt_idx  (rt_idx),
		.wb      (wb),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	execute_stage exec0 (
		.clk          (clk),
		.rst          (rst),
		.id_ex        (id_ex),
		.wb           (wb),
		.branch       (branch),
		.halt_retired (halt_retired)
	);

endmodule

/* src/cpu_cfg.svh */
// processor sizing macros
// data width, register count, reset pc and pc step

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data, instruction and address width
`define CPU_DATA_W 16

// architectural registers, r0 included
`define CPU_REG_COUNT 16

// first fetch address after reset
`define CPU_RESET_PC 16'h0000

// bytes per instruction
`define CPU_PC_STEP 16'd2

`endif

/* src/cpu_pkg.sv */
// shared types for the pipelined processor
// opcodes, branch conditions, fetch states and pipeline structs

package cpu_pkg;

`include "cpu_cfg.svh"

	typedef logic [`CPU_DATA_W-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

	// opcode field values
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h3,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_B   = 4'hC,
		OP_HLT = 4'hF
	} opcode_e;

	// branch conditions in instr bits 11:9
	typedef enum logic [2:0] {
		CC_NE,
		CC_EQ,
		CC_GT,
		CC_LT,
		CC_GE,
		CC_LE,
		CC_OV,
		CC_AL
	} cond_e;

	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
	} instr_t;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef enum logic [2:0] {
		FS_IDLE,
		FS_REQ,
		FS_RELEASE,
		FS_HOLD,
		FS_HALTED
	} fetch_state_e;

	// four-phase req/ack instruction port
	typedef struct packed {
		logic  req;
		word_t addr;
	} imem_req_t;

	typedef struct packed {
		logic  ack;
		word_t instr;
	} imem_rsp_t;

	typedef struct packed {
		logic   valid;
		instr_t instr;
		word_t  a;
		word_t  b;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
		word_t    data;
	} wb_t;

	typedef struct packed {
		logic  valid;
		logic  taken;
		word_t target;
	} branch_t;

endpackage

/* src/decode_stage.sv */
// decode stage
// source select, ex forwarding and the id/ex register

module decode_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     fetch_valid,
	input  instr_t   fetch_instr,
	output reg_idx_t rs_idx,
	output reg_idx_t rt_idx,
	input  word_t    rs_data,
	input  word_t    rt_data,
	input  wb_t      wb,
	output id_ex_t   id_ex
);

	logic  half_load;
	word_t op_a;
	word_t op_b;

	// lhb and llb read rd to keep its other byte
	assign half_load = (fetch_instr.opcode == OP_LHB) || (fetch_instr.opcode == OP_LLB);

	assign rs_idx = fetch_instr.rs;
	assign rt_idx = half_load ? fetch_instr.rd : fetch_instr.rt;

	////////////////////////////////////////////////////////////
	// forwarding from ex/wb
	////////////////////////////////////////////////////////////

	// fetch gaps are at least two cycles, so ex/wb is the only
	// producer still ahead of the register file
	always_comb begin
		if (wb.valid && (wb.dest == rs_idx) && (rs_idx != '0))
			op_a = wb.data;
		else
			op_a = rs_data;
	end

	always_comb begin
		if (wb.valid && (wb.dest == rt_idx) && (rt_idx != '0))
			op_b = wb.data;
		else
			op_b = rt_data;
	end

	////////////////////////////////////////////////////////////
	// id/ex register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// payload only moves with a new instruction
		if (fetch_valid) begin
			id_ex.instr <= fetch_instr;
			id_ex.a     <= op_a;
			id_ex.b     <= op_b;
		end
		// bubble when nothing was captured
		if (rst)
			id_ex.valid <= 1'b0;
		else
			id_ex.valid <= fetch_valid;
	end

endmodule

/* src/execute_stage.sv */
// execute stage
// saturating alu, flags, branch decision, ex/wb register and halt pulse

module execute_stage import cpu_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  id_ex_t  id_ex,
	output wb_t     wb,
	output branch_t branch,
	output logic    halt_retired
);

`include "cpu_cfg.svh"

	localparam word_t SAT_MAX = {1'b0, {(`CPU_DATA_W-1){1'b1}}};
	localparam word_t SAT_MIN = {1'b1, {(`CPU_DATA_W-1){1'b0}}};

	instr_t  ins;
	word_t   add_raw;
	word_t   sub_raw;
	logic    add_ovf;
	logic    sub_ovf;
	word_t   sat_val;
	word_t   result;
	logic    sat;
	logic    set_znv;
	logic    set_z;
	logic    writes;
	flags_t  flags;
	cond_e   cond;
	logic    cond_met;
	logic    [8:0] offset;
	word_t   ex_pc2;

	assign ins = id_ex.instr;

	////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////

	assign add_raw = id_ex.a + id_ex.b;
	assign sub_raw = id_ex.a - id_ex.b;
	// signed overflow flips the result sign away from a
	assign add_ovf = (id_ex.a[`CPU_DATA_W-1] == id_ex.b[`CPU_DATA_W-1]) &&
		(add_raw[`CPU_DATA_W-1] != id_ex.a[`CPU_DATA_W-1]);
	assign sub_ovf = (id_ex.a[`CPU_DATA_W-1] != id_ex.b[`CPU_DATA_W-1]) &&
		(sub_raw[`CPU_DATA_W-1] != id_ex.a[`CPU_DATA_W-1]);
	// clamp toward the sign of a
	assign sat_val = id_ex.a[`CPU_DATA_W-1] ? SAT_MIN : SAT_MAX;

	always_comb begin
		result  = '0;
		sat     = 1'b0;
		set_znv = 1'b0;
		set_z   = 1'b0;
		writes  = 1'b0;
		case (ins.opcode)
			OP_ADD: begin
				sat     = add_ovf;
				result  = add_ovf ? sat_val : add_raw;
				set_znv = 1'b1;
				writes  = 1'b1;
			end
			OP_SUB: begin
				sat     = sub_ovf;
				result  = sub_ovf ? sat_val : sub_raw;
				set_znv = 1'b1;
				writes  = 1'b1;
			end
			OP_XOR: begin
				result = id_ex.a ^ id_ex.b;
				set_z  = 1'b1;
				writes = 1'b1;
			end
			// shift amount is the rt field itself
			OP_SLL: begin
				result = id_ex.a << ins.rt;
				set_z  = 1'b1;
				writes = 1'b1;
			end
			OP_SRA: begin
				result = word_t'($signed(id_ex.a) >>> ins.rt);
				set_z  = 1'b1;
				writes = 1'b1;
			end
			// operand b holds the old rd
			OP_LHB: begin
				result = {ins.rs, ins.rt, id_ex.b[7:0]};
				writes = 1'b1;
			end
			OP_LLB: begin
				result = {id_ex.b[15:8], ins.rs, ins.rt};
				writes = 1'b1;
			end
			// b, hlt and unused opcodes write nothing
			default: begin
				result = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (id_ex.valid && set_znv) begin
			flags.z <= (result == '0);
			flags.v <= sat;
			flags.n <= result[`CPU_DATA_W-1];
		end else if (id_ex.valid && set_z) begin
			flags.z <= (result == '0);
		end
	end

	////////////////////////////////////////////////////////////
	// branch
	////////////////////////////////////////////////////////////

	assign cond   = cond_e'(ins.rd[3:1]);
	assign offset = {ins.rd[0], ins.rs, ins.rt};

	always_comb begin
		case (cond)
			CC_NE:   cond_met = !flags.z;
			CC_EQ:   cond_met = flags.z;
			CC_GT:   cond_met = !flags.z && !flags.n;
			CC_LT:   cond_met = flags.n;
			CC_GE:   cond_met = flags.z || (!flags.z && !flags.n);
			CC_LE:   cond_met = flags.n || flags.z;
			CC_OV:   cond_met = flags.v;
			default: cond_met = 1'b1;
		endcase
	end

	// valid for the whole b execute cycle and acted on at its end edge
	assign branch.valid  = id_ex.valid && (ins.opcode == OP_B);
	assign branch.taken  = branch.valid && cond_met;
	assign branch.target = ex_pc2 + {{6{offset[8]}}, offset, 1'b0};

	// pc+2 of the instruction in id/ex
	// fetch is in order so only steps and taken targets move it
	always_ff @(posedge clk) begin
		if (rst)
			ex_pc2 <= `CPU_RESET_PC + `CPU_PC_STEP;
		else if (branch.taken)
			ex_pc2 <= branch.target + `CPU_PC_STEP;
		else if (id_ex.valid)
			ex_pc2 <= ex_pc2 + `CPU_PC_STEP;
	end

	////////////////////////////////////////////////////////////
	// ex/wb register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		wb.dest <= ins.rd;
		wb.data <= result;
		if (rst) begin
			wb.valid     <= 1'b0;
			halt_retired <= 1'b0;
		end else begin
			// r0 targets dropped here
			wb.valid     <= id_ex.valid && writes && (ins.rd != '0);
			halt_retired <= id_ex.valid && (ins.opcode == OP_HLT);
		end
	end

	// ex/wb forwarding needs a free cycle between valid instructions
	assert property (@(posedge clk) disable iff (rst)
		id_ex.valid |=> !id_ex.valid);

endmodule

/* src/fetch_fsm.sv */
// instruction fetch state machine
// four-phase req/ack, hold on branch, halt and sticky hlt

module fetch_fsm import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  imem_rsp_t imem_rsp,
	output imem_req_t imem_req,
	input  word_t     pc,
	input  branch_t   branch,
	input  logic      halt_retired,
	output logic      fetch_valid,
	output instr_t    fetch_instr,
	output logic      pc_step,
	output logic      hlt
);

	fetch_state_e state;
	fetch_state_e state_nxt;
	instr_t       rsp_instr;
	logic         capture;

	assign rsp_instr = instr_t'(imem_rsp.instr);

	// first clock with ack high while requesting
	assign capture = (state == FS_REQ) && imem_rsp.ack;
	assign pc_step = capture;

	// req straight from state, addr follows pc
	assign imem_req.req  = (state == FS_REQ);
	assign imem_req.addr = pc;

	always_comb begin
		state_nxt = state;
		case (state)
			// wait out any ack left over from before reset
			FS_IDLE:
				if (!imem_rsp.ack)
					state_nxt = FS_REQ;
			FS_REQ:
				if (imem_rsp.ack) begin
					if (rsp_instr.opcode == OP_B)
						state_nxt = FS_HOLD;
					else if (rsp_instr.opcode == OP_HLT)
						state_nxt = FS_HALTED;
					else
						state_nxt = FS_RELEASE;
				end
			// req is low, new req only once ack seen low
			FS_RELEASE:
				if (!imem_rsp.ack)
					state_nxt = FS_REQ;
			// b in decode or execute, pc loads on the same edge
			FS_HOLD:
				if (branch.valid)
					state_nxt = FS_RELEASE;
			FS_HALTED:
				state_nxt = FS_HALTED;
			default:
				state_nxt = FS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		// captured word, held until the next capture
		if (capture)
			fetch_instr <= rsp_instr;
		if (rst) begin
			state       <= FS_IDLE;
			fetch_valid <= 1'b0;
			hlt         <= 1'b0;
		end else begin
			state       <= state_nxt;
			fetch_valid <= capture;
			// stays up until reset
			hlt         <= hlt | halt_retired;
		end
	end

	////////////////////////////////////////////////////////////
	// handshake checks
	////////////////////////////////////////////////////////////

	// no req drop before ack
	assert property (@(posedge clk) disable iff (rst)
		(imem_req.req && !imem_rsp.ack) |=> imem_req.req);

	// pc_counter must not move the address mid request
	assert property (@(posedge clk) disable iff (rst)
		(imem_req.req && $past(imem_req.req)) |-> $stable(imem_req.addr));

endmodule

/* src/pc_counter.sv */
// fetch address counter
// steps per captured instruction and loads taken branch targets

module pc_counter import cpu_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    pc_step,
	input  branch_t branch,
	output word_t   pc
);

`include "cpu_cfg.svh"

	word_t pc_nxt;

	// a taken branch has priority over the step
	always_comb begin
		if (branch.valid && branch.taken)
			pc_nxt = branch.target;
		else if (pc_step)
			pc_nxt = pc + `CPU_PC_STEP;
		else
			pc_nxt = pc;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `CPU_RESET_PC;
		else
			pc <= pc_nxt;
	end

	// fetch is held while a b is in execute
	assert property (@(posedge clk) disable iff (rst)
		!(branch.valid && pc_step));

endmodule

/* src/register_file.sv */
// register file, sixteen words
// r0 reads zero, write port bypassed to both read ports

module register_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t rs_idx,
	input  reg_idx_t rt_idx,
	input  wb_t      wb,
	output word_t    rs_data,
	output word_t    rt_data
);

`include "cpu_cfg.svh"

	word_t regs [`CPU_REG_COUNT];

	logic  wr_en;

	// r0 is never written
	assign wr_en = wb.valid && (wb.dest != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// read with same-cycle bypass
	function automatic word_t read_port(input reg_idx_t idx);
		if (idx == '0)
			return '0;
		else if (wr_en && (wb.dest == idx))
			return wb.data;
		else
			return regs[idx];
	endfunction

	assign rs_data = read_port(rs_idx);
	assign rt_data = read_port(rt_idx);

endmodule

/* verification/cpu_stim.txt */
# I addr word loads a program word, W reg data is the next expected writeback
# H pc is the pc after halt, Z lo hi is a fetch window with no ack delay, all hex
Z 16 1E
# constants and alu ops
I 00 B134  W 1 0034   # llb r1
I 02 A112  W 1 1234   # lhb r1
I 04 B20F  W 2 000F   # llb r2
I 06 0312  W 3 1243   # add r3 r1 r2
I 08 1412  W 4 1225   # sub r4 r1 r2
I 0A 3512  W 5 123B   # xor r5 r1 r2
I 0C 4614  W 6 2340   # sll r6 r1 4
I 0E A780  W 7 8000   # lhb r7
I 10 5873  W 8 F000   # sra r8 r7 3
I 12 B055             # llb r0, no write
I 14 0901  W 9 1234   # add r9 r0 r1
# dependent chain fetched back to back
I 16 0A11  W A 2468
I 18 0AAA  W A 48D0
I 1A 1BA1  W B 369C
I 1C 3BBA  W B 7E4C
I 1E 5CB2  W C 1F93
# saturation and branches
I 20 BDFF  W D 00FF
I 22 AD7F  W D 7FFF
I 24 0EDD  W E 7FFF   # add saturates, v set
I 26 CC01             # b ov taken
I 28 BFEE             # skipped
I 2A 1FDD  W F 0000   # sub sets z
I 2C C201             # b eq taken
I 2E BF11             # skipped
I 30 C001             # b ne not taken
I 32 BF22  W F 0022
I 34 0332  W 3 1252   # z clear again
I 36 C201             # b eq not taken
I 38 C001             # b ne taken
I 3A BF33             # skipped
I 3C F000             # hlt
H 3E

/* verification/cpu_tb.sv */
// testbench for the pipelined processor
// stim file loader, instruction memory responder, writeback and halt checks

module cpu_tb import cpu_pkg::*; ();

	localparam STIM_FILE = "verification/cpu_stim.txt";
	localparam int PROG_WORDS = 256;
	localparam int RUN_LIMIT  = 2000;
	localparam int DELAY_POOL = 512;

	logic      clk = 1'b0;
	logic      rst;
	imem_req_t imem_req;
	imem_rsp_t imem_rsp = '0;
	wb_t       wb;
	word_t     pc;
	logic      hlt;

	// program image and expected results
	word_t prog [PROG_WORDS];
	wb_t   exp_q [$];
	word_t halt_pc;
	word_t zero_lo;
	word_t zero_hi;
	int    exp_total;
	int    wb_count;
	int    error_count;

	// memory responder state
	int    delay_q [$];
	int    wait_left;
	logic  pending;
	logic  halt_fetched;
	logic  responder_on;

	cpu dut0 (
		.clk      (clk),
		.rst      (rst),
		.imem_req (imem_req),
		.imem_rsp (imem_rsp),
		.wb       (wb),
		.pc       (pc),
		.hlt      (hlt)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		error_count++;
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected)
			abort_run($sformatf("FAIL at %0t: %s, got %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	////////////////////////////////////////////////////////////
	// stim file
	////////////////////////////////////////////////////////////

	// one letter per record, several records may share a line
	task automatic load_stim();
		int          fd;
		int          c;
		logic [7:0]  ch;
		logic [15:0] f1;
		logic [15:0] f2;
		logic        halt_seen;
		halt_seen = 1'b0;
		zero_lo   = 16'hFFFF;
		zero_hi   = 16'h0000;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
			abort_run("could not open the stimulus file");
		c = $fgetc(fd);
		while (c != -1) begin
			ch = c[7:0];
			case (ch)
				// comment runs to end of line
				"#":
					while ((c != -1) && (c[7:0] != "\n"))
						c = $fgetc(fd);
				"I": begin
					if ($fscanf(fd, "%h %h", f1, f2) != 2)
						abort_run("malformed program line in the stimulus file");
					if (f1[0] || (f1[15:9] != '0))
						abort_run("program address outside the instruction memory");
					prog[f1[8:1]] = f2;
				end
				"W": begin
					if ($fscanf(fd, "%h %h", f1, f2) != 2)
						abort_run("malformed writeback line in the stimulus file");
					exp_q.push_back('{valid: 1'b1, dest: f1[3:0], data: f2});
				end
				"H": begin
					if ($fscanf(fd, "%h", halt_pc) != 1)
						abort_run("malformed halt line in the stimulus file");
					halt_seen = 1'b1;
				end
				"Z":
					if ($fscanf(fd, "%h %h", zero_lo, zero_hi) != 2)
						abort_run("malformed zero delay line in the stimulus file");
				" ", "\t", "\r", "\n": begin
				end
				default:
					abort_run("unknown record type in the stimulus file");
			endcase
			c = $fgetc(fd);
		end
		$fclose(fd);
		if (!halt_seen)
			abort_run("the stimulus file gives no halt pc");
		exp_total = exp_q.size();
	endtask

	////////////////////////////////////////////////////////////
	// instruction memory, four-phase responder
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst || !responder_on) begin
			imem_rsp     = '0;
			pending      = 1'b0;
			halt_fetched = 1'b0;
		end else if (imem_rsp.ack) begin
			// release once req is gone
			if (!imem_req.req)
				imem_rsp.ack = 1'b0;
		end else if (imem_req.req) begin
			if (halt_fetched)
				abort_run("an instruction request came after HLT was fetched");
			if (imem_req.addr[0] || (imem_req.addr[15:9] != '0))
				abort_run("fetch address outside the instruction memory");
			// new request, pick its ack delay
			if (!pending) begin
				pending = 1'b1;
				if ((imem_req.addr >= zero_lo) && (imem_req.addr <= zero_hi))
					wait_left = 0;
				else if (delay_q.size() > 0)
					wait_left = delay_q.pop_front();
				else
					wait_left = 0;
			end
			if (wait_left == 0) begin
				pending        = 1'b0;
				imem_rsp.ack   = 1'b1;
				imem_rsp.instr = prog[imem_req.addr[8:1]];
				// hlt opcode, nothing may be requested after it
				if (imem_rsp.instr[15:12] == 4'hF)
					halt_fetched = 1'b1;
			end else begin
				wait_left--;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// writeback tracking
	////////////////////////////////////////////////////////////

	task automatic match_writeback();
		wb_t exp;
		if (exp_q.size() == 0)
			abort_run("the DUT wrote back more results than the stimulus file lists");
		exp = exp_q.pop_front();
		wb_count++;
		check_eq(32'(wb.dest), 32'(exp.dest), $sformatf("writeback %0d register", wb_count));
		check_eq(32'(wb.data), 32'(exp.data), $sformatf("writeback %0d data", wb_count));
	endtask

	task automatic run_to_halt();
		int cycles;
		cycles = 0;
		while (!hlt) begin
			@(negedge clk);
			cycles++;
			if (wb.valid)
				match_writeback();
			if (cycles >= RUN_LIMIT)
				abort_run($sformatf("hlt did not rise within %0d cycles", RUN_LIMIT));
		end
	endtask

	initial begin
		rst          = 1'b1;
		responder_on = 1'b0;
		error_count  = 0;
		wb_count     = 0;
		// unloaded words are hlt with the word index below
		for (int i = 0; i < PROG_WORDS; i++)
			prog[i] = {4'hF, 4'h0, 8'(i)};
		void'($urandom(32'h2f80880c));
		repeat (DELAY_POOL)
			delay_q.push_back(int'($urandom % 6));
		load_stim();

		// two reset cycles
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_eq(32'(imem_req.req), 32'd0, "req in reset");
		check_eq(32'(wb.valid), 32'd0, "wb.valid in reset");
		check_eq(32'(hlt), 32'd0, "hlt in reset");
		check_eq(32'(pc), 32'd0, "pc in reset");
		rst = 1'b0;

		// memory silent, nothing should move
		repeat (3) begin
			@(negedge clk);
			check_eq(32'(pc), 32'd0, "pc with no ack");
			check_eq(32'(hlt), 32'd0, "hlt with no ack");
			check_eq(32'(wb.valid), 32'd0, "wb.valid with no ack");
		end
		responder_on = 1'b1;

		run_to_halt();
		check_eq(32'(pc), 32'(halt_pc), "pc after halt");
		check_eq(32'(wb_count), 32'(exp_total), "writeback count");

		// hlt sticky, pipeline quiet
		repeat (10) begin
			@(negedge clk);
			check_eq(32'(hlt), 32'd1, "hlt after halt");
			check_eq(32'(wb.valid), 32'd0, "wb.valid after halt");
		end

		if (error_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "simulation stopped");
		end
	end

endmodule
